// File: Makefile
# Verilator build and run of the register access subsystem testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module tb_dma_subsystem -o sim_dma
	@out=$$(./obj_dir/sim_dma); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module tb_dma_subsystem

clean:
	rm -rf obj_dir

// File: src/channel_register_bank.sv
// Register storage of one channel; instantiated once per channel by the subsystem top
`timescale 1ns/1ps

module channel_register_bank import dma_pkg::*; #(
    parameter int CHANNEL_INDEX = 0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  bank_wr_en,
    input  logic [ADDR_WIDTH-1:0] bank_wr_addr,
    input  logic [DATA_WIDTH-1:0] bank_wr_data,
    input  logic [ADDR_WIDTH-1:0] bank_rd_addr,
    output logic [DATA_WIDTH-1:0] bank_rd_data
);

    logic [DATA_WIDTH-1:0] registers [2**REG_BITS];
    dma_addr_u             wr_addr;
    dma_addr_u             rd_addr;
    logic                  wr_hit;

    always_comb begin
        wr_addr.flat = bank_wr_addr;
        rd_addr.flat = bank_rd_addr;
    end

    // Every bank sees every write, only the one with the matching channel keeps it
    assign wr_hit = bank_wr_en && (wr_addr.split.channel == CHANNEL_BITS'(CHANNEL_INDEX));

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < 2**REG_BITS; i++) begin
                registers[i] <= '0;
            end
        end else if (wr_hit) begin
            registers[wr_addr.split.register_index] <= bank_wr_data;
        end
    end

    // Read every cycle regardless of channel, the collector picks the right bank
    always_ff @(posedge clock) begin
        bank_rd_data <= registers[rd_addr.split.register_index];
    end

endmodule

// File: src/dma_bus_port.sv
// Processor bus slave; turns each four-phase req/ack transaction into one endpoint command
`timescale 1ns/1ps

module dma_bus_port import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  bus_req,
    input  logic                  bus_write,
    input  logic [ADDR_WIDTH-1:0] bus_addr,
    input  logic [DATA_WIDTH-1:0] bus_wdata,
    output logic                  bus_ack,
    output logic [DATA_WIDTH-1:0] bus_rdata,
    output logic                  cmd_valid,
    output logic                  cmd_write,
    output logic [ADDR_WIDTH-1:0] cmd_addr,
    output logic [DATA_WIDTH-1:0] cmd_wdata,
    input  logic                  cmd_done,
    input  logic [DATA_WIDTH-1:0] cmd_rdata
);

    enum logic [1:0] {
        idle,
        issue,
        wait_done,
        wait_release
    } state;

    // The command is offered for exactly one cycle, the endpoint keeps it pending
    assign cmd_valid = (state == issue);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= idle;
            bus_ack <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (bus_req) begin
                        state <= issue;
                    end
                end
                issue: begin
                    state <= wait_done;
                end
                wait_done: begin
                    // Stream traffic may hold the command back for a while
                    if (cmd_done) begin
                        bus_ack <= 1'b1;
                        state   <= wait_release;
                    end
                end
                wait_release: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // The host keeps address and data stable while req is high, one capture is enough
    always_ff @(posedge clock) begin
        if (state == idle && bus_req) begin
            cmd_write <= bus_write;
            cmd_addr  <= bus_addr;
            cmd_wdata <= bus_wdata;
        end
        if (state == wait_done && cmd_done) begin
            bus_rdata <= cmd_rdata;
        end
    end

endmodule

// File: src/dma_endpoint.sv
// Arbitrates bus commands and DMA streams onto the channel banks and holds the channel count
`timescale 1ns/1ps

module dma_endpoint import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  logic                  cmd_write,
    input  logic [ADDR_WIDTH-1:0] cmd_addr,
    input  logic [DATA_WIDTH-1:0] cmd_wdata,
    output logic                  cmd_done,
    output logic [DATA_WIDTH-1:0] cmd_rdata,
    input  logic                  stream_wr_valid,
    input  logic [ADDR_WIDTH-1:0] stream_wr_dest,
    input  logic [DATA_WIDTH-1:0] stream_wr_data,
    input  logic                  read_req_valid,
    input  logic [ADDR_WIDTH-1:0] read_req_addr,
    output logic                  read_req_ready,
    output logic                  read_resp_valid,
    output logic [DATA_WIDTH-1:0] read_resp_data,
    input  logic                  read_resp_ready,
    output logic                  bank_wr_en,
    output logic [ADDR_WIDTH-1:0] bank_wr_addr,
    output logic [DATA_WIDTH-1:0] bank_wr_data,
    output logic [ADDR_WIDTH-1:0] bank_rd_addr,
    input  logic [DATA_WIDTH-1:0] collected_data,
    output logic [CHANNEL_BITS:0] active_channels
);

    enum logic [1:0] {
        rd_idle,
        bus_wait,
        stream_wait,
        respond
    } rd_state;

    logic                       bus_pending;
    logic                       bus_wr_go;
    logic                       bus_rd_go;
    logic                       wr_go;
    dma_addr_u                  wr_addr;
    logic [DATA_WIDTH-1:0]      wr_data;
    dma_addr_u                  rd_addr;
    logic [READ_COUNT_BITS-1:0] rd_count;
    logic                       rd_count_done;
    logic                       rd_fixed;
    logic [DATA_WIDTH-1:0]      rd_fixed_data;
    logic [DATA_WIDTH-1:0]      rd_word;

    // True when the address lands in a bank of an active channel
    function automatic logic bank_hit(input dma_addr_u addr, input logic [CHANNEL_BITS:0] limit);
        return (addr.flat != '0) && ({1'b0, addr.split.channel} < limit);
    endfunction

    // Stream writes win the write port, a pending bus write waits for a free cycle
    assign bus_wr_go = bus_pending && cmd_write && !stream_wr_valid;
    assign bus_rd_go = bus_pending && !cmd_write && !read_req_valid && rd_state == rd_idle;
    assign wr_go     = stream_wr_valid || bus_wr_go;

    always_comb begin
        wr_addr.flat = stream_wr_valid ? stream_wr_dest : cmd_addr;
        wr_data      = stream_wr_valid ? stream_wr_data : cmd_wdata;
        rd_addr.flat = read_req_valid ? read_req_addr : cmd_addr;
    end

    assign read_req_ready = (rd_state == rd_idle);
    assign rd_count_done  = (rd_count == READ_COUNT_BITS'(READ_LATENCY));
    assign rd_word        = rd_fixed ? rd_fixed_data : collected_data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            bus_pending     <= 1'b0;
            cmd_done        <= 1'b0;
            bank_wr_en      <= 1'b0;
            active_channels <= (CHANNEL_BITS + 1)'(N_CHANNELS);
            rd_state        <= rd_idle;
            rd_count        <= '0;
            read_resp_valid <= 1'b0;
            bank_rd_addr    <= '0;
        end else begin
            cmd_done   <= 1'b0;
            bank_wr_en <= 1'b0;
            if (cmd_valid) begin
                bus_pending <= 1'b1;
            end
            if (wr_go) begin
                if (wr_addr.flat == '0) begin
                    active_channels <= wr_data[CHANNEL_BITS:0];
                end else if (bank_hit(wr_addr, active_channels)) begin
                    bank_wr_en <= 1'b1;
                end
            end
            if (bus_wr_go) begin
                cmd_done    <= 1'b1;
                bus_pending <= 1'b0;
            end
            case (rd_state)
                rd_idle: begin
                    if (read_req_valid || bus_rd_go) begin
                        bank_rd_addr <= rd_addr.flat;
                        rd_count     <= '0;
                        rd_state     <= read_req_valid ? stream_wait : bus_wait;
                    end
                end
                bus_wait: begin
                    if (rd_count_done) begin
                        cmd_done    <= 1'b1;
                        bus_pending <= 1'b0;
                        rd_state    <= rd_idle;
                    end else begin
                        rd_count <= rd_count + 1'b1;
                    end
                end
                stream_wait: begin
                    if (rd_count_done) begin
                        read_resp_valid <= 1'b1;
                        rd_state        <= respond;
                    end else begin
                        rd_count <= rd_count + 1'b1;
                    end
                end
                respond: begin
                    // Held until the consumer takes it
                    if (read_resp_ready) begin
                        read_resp_valid <= 1'b0;
                        rd_state        <= rd_idle;
                    end
                end
                default: begin
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_go) begin
            bank_wr_addr <= wr_addr.flat;
            bank_wr_data <= wr_data;
        end
        // Config reads and inactive channels bypass the bank data
        if (rd_state == rd_idle) begin
            rd_fixed      <= !bank_hit(rd_addr, active_channels);
            rd_fixed_data <= (rd_addr.flat == '0) ? DATA_WIDTH'(active_channels) : '0;
        end
        if (rd_state == bus_wait && rd_count_done) begin
            cmd_rdata <= rd_word;
        end
        if (rd_state == stream_wait && rd_count_done) begin
            read_resp_data <= rd_word;
        end
    end

endmodule

// File: src/dma_pkg.sv
// Shared sizing constants and the register address view used by every block of the subsystem
package dma_pkg;

    // Width of one register word
    localparam int DATA_WIDTH = 20;

    // Width of a flat register address
    localparam int ADDR_WIDTH = 8;

    // The flat address splits into a channel field and a register field
    localparam int CHANNEL_BITS = 3;
    localparam int REG_BITS = 5;

    // Number of channel banks that are actually built
    localparam int N_CHANNELS = 4;

    // Cycles from a read address leaving the endpoint to valid collector data
    localparam int READ_LATENCY = 2;

    // Width of the endpoint counter that waits out the read pipeline
    localparam int READ_COUNT_BITS = $clog2(READ_LATENCY + 1);

    // One address word seen two ways.
    // The endpoint looks at the flat word to find the configuration register at 0,
    // while the banks and the collector look at the channel and register fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [CHANNEL_BITS-1:0] channel;
            logic [REG_BITS-1:0]     register_index;
        } split;
    } dma_addr_u;

    // Channel 0 register 0 shares the flat address of the configuration register,
    // so that bank location can never be reached from outside

endpackage

// File: src/dma_subsystem.sv
// Top of the register access subsystem; wires the bus port, endpoint, channel banks and collector
`timescale 1ns/1ps

module dma_subsystem import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  bus_req,
    input  logic                  bus_write,
    input  logic [ADDR_WIDTH-1:0] bus_addr,
    input  logic [DATA_WIDTH-1:0] bus_wdata,
    output logic                  bus_ack,
    output logic [DATA_WIDTH-1:0] bus_rdata,
    input  logic                  stream_wr_valid,
    input  logic [ADDR_WIDTH-1:0] stream_wr_dest,
    input  logic [DATA_WIDTH-1:0] stream_wr_data,
    input  logic                  read_req_valid,
    input  logic [ADDR_WIDTH-1:0] read_req_addr,
    output logic                  read_req_ready,
    output logic                  read_resp_valid,
    output logic [DATA_WIDTH-1:0] read_resp_data,
    input  logic                  read_resp_ready,
    output logic [CHANNEL_BITS:0] active_channels
);

    logic                  cmd_valid;
    logic                  cmd_write;
    logic [ADDR_WIDTH-1:0] cmd_addr;
    logic [DATA_WIDTH-1:0] cmd_wdata;
    logic                  cmd_done;
    logic [DATA_WIDTH-1:0] cmd_rdata;
    logic                  bank_wr_en;
    logic [ADDR_WIDTH-1:0] bank_wr_addr;
    logic [DATA_WIDTH-1:0] bank_wr_data;
    logic [ADDR_WIDTH-1:0] bank_rd_addr;
    logic [DATA_WIDTH-1:0] bank_rd_data [N_CHANNELS];
    logic [DATA_WIDTH-1:0] collected_data;

    dma_bus_port bus_port_i (
        .clock     (clock),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_done  (cmd_done),
        .cmd_rdata (cmd_rdata)
    );

    dma_endpoint endpoint_i (
        .clock           (clock),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd_write       (cmd_write),
        .cmd_addr        (cmd_addr),
        .cmd_wdata       (cmd_wdata),
        .cmd_done        (cmd_done),
        .cmd_rdata       (cmd_rdata),
        .stream_wr_valid (stream_wr_valid),
        .stream_wr_dest  (stream_wr_dest),
        .stream_wr_data  (stream_wr_data),
        .read_req_valid  (read_req_valid),
        .read_req_addr   (read_req_addr),
        .read_req_ready  (read_req_ready),
        .read_resp_valid (read_resp_valid),
        .read_resp_data  (read_resp_data),
        .read_resp_ready (read_resp_ready),
        .bank_wr_en      (bank_wr_en),
        .bank_wr_addr    (bank_wr_addr),
        .bank_wr_data    (bank_wr_data),
        .bank_rd_addr    (bank_rd_addr),
        .collected_data  (collected_data),
        .active_channels (active_channels)
    );

    // One bank per channel, each one knows its own channel number
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_bank
        channel_register_bank #(
            .CHANNEL_INDEX (i)
        ) bank_i (
            .clock        (clock),
            .reset        (reset),
            .bank_wr_en   (bank_wr_en),
            .bank_wr_addr (bank_wr_addr),
            .bank_wr_data (bank_wr_data),
            .bank_rd_addr (bank_rd_addr),
            .bank_rd_data (bank_rd_data[i])
        );
    end

    read_collector collector_i (
        .clock          (clock),
        .reset          (reset),
        .bank_rd_addr   (bank_rd_addr),
        .bank_rd_data   (bank_rd_data),
        .collected_data (collected_data)
    );

endmodule

// File: src/read_collector.sv
// Picks the addressed bank's read word and registers it for the endpoint
`timescale 1ns/1ps

module read_collector import dma_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] bank_rd_addr,
    input  logic [DATA_WIDTH-1:0] bank_rd_data [N_CHANNELS],
    output logic [DATA_WIDTH-1:0] collected_data
);

    dma_addr_u               rd_addr;
    logic [CHANNEL_BITS-1:0] channel_q;
    logic [DATA_WIDTH-1:0]   selected;

    assign rd_addr.flat = bank_rd_addr;

    // Channel numbers with no bank behind them fall through to zero
    always_comb begin
        selected = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (channel_q == CHANNEL_BITS'(i)) begin
                selected = bank_rd_data[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            channel_q      <= '0;
            collected_data <= '0;
        end else begin
            // Delayed one cycle so it matches the registered bank output
            channel_q      <= rd_addr.split.channel;
            collected_data <= selected;
        end
    end

endmodule

// File: tb.f
src/dma_pkg.sv
src/dma_bus_port.sv
src/dma_endpoint.sv
src/channel_register_bank.sv
src/read_collector.sv
src/dma_subsystem.sv
verification/dma_subsystem_sva.sv
verification/tb_dma_subsystem.sv

// File: verification/dma_golden.txt
# Columns: op addr value aux, numbers in hex; aux is the bus data of an SB line, otherwise 0
# BW/BR bus write/read, SW/SR stream write/read, SB stream and bus write together, AC count
AC 00 00004 0
BR 00 00004 0
BW 23 abcde 0
SW 41 12345 0
SW 05 0f0f0 0
BW 67 55aa5 0
SR 23 abcde 0
BR 41 12345 0
SR 05 0f0f0 0
SR 67 55aa5 0
BR 23 abcde 0
SB 2a 11111 22222
BR 2a 22222 0
SR 2a 22222 0
BW 80 fffff 0
SR 80 00000 0
BR e2 00000 0
BW 00 00002 0
AC 00 00002 0
BR 00 00002 0
SW 41 77777 0
BW 67 33333 0
SR 41 00000 0
BR 67 00000 0
SR 23 abcde 0
BR 05 0f0f0 0
SW 00 00004 0
AC 00 00004 0
SR 41 12345 0
SR 67 55aa5 0
BR 2a 22222 0

// File: verification/dma_subsystem_sva.sv
// Protocol rules for the bus handshake and the read streams; bound onto the subsystem top
`timescale 1ns/1ps

module dma_subsystem_sva import dma_pkg::*; (
    input logic                  clock,
    input logic                  reset,
    input logic                  bus_req,
    input logic                  bus_ack,
    input logic                  read_req_ready,
    input logic                  read_resp_valid,
    input logic                  read_resp_ready,
    input logic [DATA_WIDTH-1:0] read_resp_data
);

    // Read by the testbench at the end of the run
    int failure_count = 0;

    // Ack may only answer a request that was up on the cycle before
    ack_follows_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(bus_ack) |-> $past(bus_req))
    else begin
        failure_count++;
        $error("bus_ack rose without a pending bus_req");
    end

    // A response that is not taken has to wait unchanged
    resp_held: assert property (@(posedge clock) disable iff (!reset)
        read_resp_valid && !read_resp_ready |=> read_resp_valid && $stable(read_resp_data))
    else begin
        failure_count++;
        $error("read response changed or vanished under back-pressure");
    end

    req_blocked: assert property (@(posedge clock) disable iff (!reset)
        read_resp_valid |-> !read_req_ready)
    else begin
        failure_count++;
        $error("read_req_ready high while a response is pending");
    end

endmodule

bind dma_subsystem dma_subsystem_sva rules_i (.*);

// File: verification/tb_dma_subsystem.sv
// Testbench for the register access subsystem; replays the golden command list and checks results
`timescale 1ns/1ps

module tb_dma_subsystem import dma_pkg::*; ();

    logic                  clock;
    logic                  reset;
    logic                  bus_req;
    logic                  bus_write;
    logic [ADDR_WIDTH-1:0] bus_addr;
    logic [DATA_WIDTH-1:0] bus_wdata;
    logic                  bus_ack;
    logic [DATA_WIDTH-1:0] bus_rdata;
    logic                  stream_wr_valid;
    logic [ADDR_WIDTH-1:0] stream_wr_dest;
    logic [DATA_WIDTH-1:0] stream_wr_data;
    logic                  read_req_valid;
    logic [ADDR_WIDTH-1:0] read_req_addr;
    logic                  read_req_ready;
    logic                  read_resp_valid;
    logic [DATA_WIDTH-1:0] read_resp_data;
    logic                  read_resp_ready;
    logic [CHANNEL_BITS:0] active_channels;

    logic [15:0]           op_q[$];
    logic [ADDR_WIDTH-1:0] addr_q[$];
    logic [DATA_WIDTH-1:0] value_q[$];
    logic [DATA_WIDTH-1:0] aux_q[$];
    logic                  list_loaded = 1'b0;
    logic [31:0]           rng_state = 32'h4c7f_cc46;
    int                    check_total = 0;
    int                    mismatch_count = 0;
    int                    fault_count = 0;

    dma_subsystem dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected);
        check_total++;
        if (got !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input logic [CHANNEL_BITS:0] got,
                               input logic [CHANNEL_BITS:0] expected);
        check_total++;
        if (got !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    // One full four-phase transaction, ending once ack has dropped again
    task automatic bus_access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata);
        @(negedge clock);
        bus_write = write;
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_req   = 1'b1;
        while (!bus_ack) @(negedge clock);
        rdata   = bus_rdata;
        bus_req = 1'b0;
        while (bus_ack) @(negedge clock);
    endtask

    task automatic stream_write(input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data, input int cycles);
        @(negedge clock);
        stream_wr_valid = 1'b1;
        stream_wr_dest  = addr;
        stream_wr_data  = data;
        repeat (cycles) @(negedge clock);
        stream_wr_valid = 1'b0;
    endtask

    // Ready is sampled on the falling edge, where it already holds its value for the next edge
    task automatic stream_read(input logic [ADDR_WIDTH-1:0] addr,
                               output logic [DATA_WIDTH-1:0] data);
        @(negedge clock);
        read_req_valid = 1'b1;
        read_req_addr  = addr;
        while (!read_req_ready) @(negedge clock);
        @(negedge clock);
        read_req_valid  = 1'b0;
        rng_state       = lcg_next(rng_state);
        read_resp_ready = rng_state[28];
        while (!(read_resp_valid && read_resp_ready)) begin
            @(negedge clock);
            rng_state       = lcg_next(rng_state);
            read_resp_ready = rng_state[28];
        end
        data = read_resp_data;
        @(negedge clock);
        read_resp_ready = 1'b0;
        if (read_resp_valid) begin
            fault_count++;
            $display("ERROR: read response still offered after it was taken");
        end
    endtask

    initial begin
        int                    fd;
        int                    status;
        int                    c;
        logic                  reading;
        logic [15:0]           op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] value;
        logic [DATA_WIDTH-1:0] aux;
        logic [DATA_WIDTH-1:0] got;
        reset           = 1'b0;
        bus_req         = 1'b0;
        bus_write       = 1'b0;
        bus_addr        = '0;
        bus_wdata       = '0;
        stream_wr_valid = 1'b0;
        stream_wr_dest  = '0;
        stream_wr_data  = '0;
        read_req_valid  = 1'b0;
        read_req_addr   = '0;
        read_resp_ready = 1'b0;
        fd = $fopen("verification/dma_golden.txt", "r");
        if (fd == 0) begin
            fault_count++;
            $display("ERROR: the golden command file could not be opened");
        end else begin
            reading = 1'b1;
            while (reading) begin
                status = $fscanf(fd, "%s", op);
                if (status != 1) begin
                    reading = 1'b0;
                end else if (op == 16'("#")) begin
                    // Skip the rest of a comment line, 10 is a newline
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) c = $fgetc(fd);
                end else if ($fscanf(fd, "%h %h %h", addr, value, aux) == 3) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    value_q.push_back(value);
                    aux_q.push_back(aux);
                end else begin
                    fault_count++;
                    $display("ERROR: a golden line has too few fields");
                    reading = 1'b0;
                end
            end
            $fclose(fd);
        end
        list_loaded = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        foreach (op_q[i]) begin
            case (op_q[i])
                "BW": bus_access(1'b1, addr_q[i], value_q[i], got);
                "BR": begin
                    bus_access(1'b0, addr_q[i], '0, got);
                    check_word("bus_rdata", got, value_q[i]);
                end
                "SW": stream_write(addr_q[i], value_q[i], 1);
                "SR": begin
                    stream_read(addr_q[i], got);
                    check_word("read_resp_data", got, value_q[i]);
                end
                // The stream keeps the write port busy so the bus write has to wait
                "SB": fork
                    stream_write(addr_q[i], value_q[i], 4);
                    bus_access(1'b1, addr_q[i], aux_q[i], got);
                join
                "AC": begin
                    @(negedge clock);
                    check_count("active_channels", active_channels, value_q[i][CHANNEL_BITS:0]);
                end
                default: begin
                    fault_count++;
                    $display("ERROR: unknown command in golden line %0d", i);
                end
            endcase
        end
        repeat (4) @(negedge clock);
        fault_count += dut_i.rules_i.failure_count;
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_total, mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0 && check_total > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Each golden line gets a generous cycle budget, the extra line covers reset
    initial begin
        wait (list_loaded);
        repeat ((op_q.size() + 1) * 200) @(posedge clock);
        $display("ERROR: timeout, the command list did not finish within its cycle budget");
        $display("Regression failed");
        $finish;
    end

endmodule
